// File: Bender.yml
package:
  name: spi_cmd

export_include_dirs:
  - hdl

sources:
  - hdl/spi_cmd_pkg.sv
  - hdl/cmd_parser.sv
  - hdl/buf_allocator.sv
  - hdl/reply_serializer.sv
  - hdl/spi_cmd_top.sv
  - target: simulation
    files:
      - tb/spi_cmd_checker.sv
      - tb/tb_spi_cmd.sv

// File: hdl/buf_allocator.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module buf_allocator #(
    parameter int ADDR_W = 13,
    parameter int CAPACITY = 8192
) (
    input  logic                 sck,
    input  logic                 rst,
    input  logic                 alloc_req,
    input  spi_cmd_pkg::count_t  count,
    output logic                 hdr_valid,
    output spi_cmd_pkg::buf_id_t id,
    output logic [ADDR_W-1:0]    base,
    output spi_cmd_pkg::status_e alloc_status,
    output spi_cmd_pkg::count_t  hdr_count
);
    logic [ADDR_W:0] next_base;   // can reach CAPACITY itself
    logic [ADDR_W+`SPI_CNT_W:0] end_addr;
    spi_cmd_pkg::buf_id_t next_id;
    logic fits;

    assign end_addr = next_base + count;
    assign fits = (end_addr <= CAPACITY);

    always_ff @(posedge sck) begin
        if (rst) begin
            hdr_valid <= 1'b0;
            next_id <= '0;
            next_base <= '0;
            alloc_status <= spi_cmd_pkg::ST_OK;
        end else begin
            hdr_valid <= alloc_req;
            if (alloc_req) begin
                if (fits) begin
                    alloc_status <= spi_cmd_pkg::ST_OK;
                    next_id <= next_id + 1'b1;
                    next_base <= end_addr[ADDR_W:0];
                end else begin
                    alloc_status <= spi_cmd_pkg::ST_OUT_OF_MEMORY;   // nothing advances
                end
            end
        end
    end

    // header fields held until the next request
    always_ff @(posedge sck) begin
        if (alloc_req) begin
            id <= next_id;
            base <= next_base[ADDR_W-1:0];
            hdr_count <= count;
        end
    end

    a_base_in_range: assert property (@(posedge sck) disable iff (rst)
        next_base <= CAPACITY);

endmodule

`default_nettype wire

// File: hdl/cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module cmd_parser (
    input  logic                 sck,
    input  logic                 rst,
    input  logic                 cs_n,
    input  spi_cmd_pkg::nibble_t spi_in,
    input  spi_cmd_pkg::status_e vert_status,
    input  spi_cmd_pkg::status_e tri_status,
    input  logic                 reply_done,
    output logic                 vert_alloc_req,
    output logic                 tri_alloc_req,
    output spi_cmd_pkg::count_t  count,
    output logic                 vert_valid,
    output spi_cmd_pkg::vertex_t vert_data,
    output logic                 tri_valid,
    output spi_cmd_pkg::tri_t    tri_data,
    output logic                 reply_start,
    output spi_cmd_pkg::opcode_e reply_kind,
    output spi_cmd_pkg::status_e reply_status
);
    localparam int SETTLE_W = $clog2(`SPI_SETTLE_CYC + 1);
    localparam int NBL_CNT_W = $clog2(`SPI_VTX_NBL);

    logic [SETTLE_W-1:0] settle_cnt;
    logic settled;
    logic active;
    spi_cmd_pkg::parse_state_e state;
    spi_cmd_pkg::opcode_e op_kind;
    logic [NBL_CNT_W-1:0] nbl_cnt;   // nibble within count or item
    spi_cmd_pkg::count_t item_cnt;
    logic op_ready;
    logic op_vert;
    logic op_tri;
    logic item_last;

    // input is junk for the first few cycles of a frame
    always_ff @(posedge sck) begin
        if (rst || cs_n) begin
            settle_cnt <= '0;
        end else if (!settled) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    assign settled = (settle_cnt == SETTLE_W'(`SPI_SETTLE_CYC));
    assign active = !cs_n && settled;

    // opcode may also land on the cycle after the reply ends
    assign op_ready = (state == spi_cmd_pkg::PS_OP) ||
                      (state == spi_cmd_pkg::PS_REPLY && reply_done);
    assign op_vert = (spi_in == spi_cmd_pkg::OP_CREATE_VERT);
    assign op_tri = (spi_in == spi_cmd_pkg::OP_CREATE_TRI);
    assign item_last = (state == spi_cmd_pkg::PS_VERT) ?
                       (nbl_cnt == NBL_CNT_W'(`SPI_VTX_NBL - 1)) :
                       (nbl_cnt == NBL_CNT_W'(`SPI_TRI_NBL - 1));

    assign reply_start = active && ((op_ready && !op_vert && !op_tri) ||
                                    state == spi_cmd_pkg::PS_DONE);
    assign reply_kind = op_kind;

    always_comb begin
        if (state == spi_cmd_pkg::PS_DONE) begin
            reply_status = (op_kind == spi_cmd_pkg::OP_CREATE_TRI) ? tri_status : vert_status;
        end else begin
            reply_status = spi_cmd_pkg::ST_INVALID_OPCODE;
        end
    end

    always_ff @(posedge sck) begin
        if (rst) begin
            state <= spi_cmd_pkg::PS_OP;
            op_kind <= spi_cmd_pkg::OP_CREATE_VERT;
            nbl_cnt <= '0;
            item_cnt <= '0;
            vert_alloc_req <= 1'b0;
            tri_alloc_req <= 1'b0;
            vert_valid <= 1'b0;
            tri_valid <= 1'b0;
        end else begin
            vert_alloc_req <= 1'b0;
            tri_alloc_req <= 1'b0;
            vert_valid <= 1'b0;
            tri_valid <= 1'b0;
            if (cs_n) begin
                state <= spi_cmd_pkg::PS_OP;
            end else if (settled) begin
                case (state)
                    spi_cmd_pkg::PS_OP, spi_cmd_pkg::PS_REPLY: begin
                        if (op_ready) begin
                            nbl_cnt <= '0;
                            if (op_vert || op_tri) begin
                                op_kind <= op_vert ? spi_cmd_pkg::OP_CREATE_VERT :
                                                     spi_cmd_pkg::OP_CREATE_TRI;
                                state <= spi_cmd_pkg::PS_CNT;
                            end else begin
                                state <= spi_cmd_pkg::PS_REPLY;   // status-only reply
                            end
                        end
                    end
                    spi_cmd_pkg::PS_CNT: begin
                        if (nbl_cnt == NBL_CNT_W'(`SPI_CNT_NBL - 1)) begin
                            nbl_cnt <= '0;
                            item_cnt <= '0;
                            vert_alloc_req <= (op_kind == spi_cmd_pkg::OP_CREATE_VERT);
                            tri_alloc_req <= (op_kind == spi_cmd_pkg::OP_CREATE_TRI);
                            state <= (op_kind == spi_cmd_pkg::OP_CREATE_TRI) ?
                                     spi_cmd_pkg::PS_TRI : spi_cmd_pkg::PS_VERT;
                        end else begin
                            nbl_cnt <= nbl_cnt + 1'b1;
                        end
                    end
                    spi_cmd_pkg::PS_VERT, spi_cmd_pkg::PS_TRI: begin
                        if (item_last) begin
                            nbl_cnt <= '0;
                            // no item goes to memory after a failed allocation
                            vert_valid <= (state == spi_cmd_pkg::PS_VERT) &&
                                          (vert_status == spi_cmd_pkg::ST_OK);
                            tri_valid <= (state == spi_cmd_pkg::PS_TRI) &&
                                         (tri_status == spi_cmd_pkg::ST_OK);
                            if (item_cnt == count - 1'b1) begin
                                state <= spi_cmd_pkg::PS_DONE;
                            end else begin
                                item_cnt <= item_cnt + 1'b1;
                            end
                        end else begin
                            nbl_cnt <= nbl_cnt + 1'b1;
                        end
                    end
                    spi_cmd_pkg::PS_DONE: state <= spi_cmd_pkg::PS_REPLY;
                    default: state <= spi_cmd_pkg::PS_OP;
                endcase
            end
        end
    end

    // count, vertex and triangle shifters take the msn first
    always_ff @(posedge sck) begin
        if (active) begin
            if (state == spi_cmd_pkg::PS_CNT) begin
                count <= {count[`SPI_CNT_W-`SPI_NBL_W-1:0], spi_in};
            end
            if (state == spi_cmd_pkg::PS_VERT) begin
                vert_data <= {vert_data[`SPI_VTX_W-`SPI_NBL_W-1:0], spi_in};
            end
            if (state == spi_cmd_pkg::PS_TRI) begin
                tri_data <= {tri_data[`SPI_TRI_W-`SPI_NBL_W-1:0], spi_in};
            end
        end
    end

    // host never asks for an empty buffer
    a_count_nonzero: assert property (@(posedge sck) disable iff (rst)
        (vert_alloc_req || tri_alloc_req) |-> count != '0);

    // serializer drives the bus for the three cycles after reply_start
    a_no_valid_in_reply: assert property (@(posedge sck) disable iff (rst)
        reply_start |=> (!vert_valid && !tri_valid) [*3]);

endmodule

`default_nettype wire

// File: hdl/reply_serializer.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module reply_serializer (
    input  logic                 sck,
    input  logic                 rst,
    input  logic                 reply_start,
    input  spi_cmd_pkg::opcode_e reply_kind,
    input  spi_cmd_pkg::buf_id_t vert_id,
    input  spi_cmd_pkg::buf_id_t tri_id,
    input  spi_cmd_pkg::status_e reply_status,
    output spi_cmd_pkg::nibble_t spi_out,
    output logic                 spi_oe,
    output logic                 reply_done
);
    localparam int REP_W = `SPI_ID_W + `SPI_NBL_W;
    localparam int LEFT_W = $clog2(`SPI_ID_NBL + 1);

    logic [REP_W-1:0] rep_sr;       // id then status
    logic [LEFT_W-1:0] nbl_left;
    logic status_only;

    assign status_only = (reply_status == spi_cmd_pkg::ST_INVALID_OPCODE);
    assign spi_out = rep_sr[REP_W-1 -: `SPI_NBL_W];

    always_ff @(posedge sck) begin
        if (rst) begin
            spi_oe <= 1'b0;
            nbl_left <= '0;
            reply_done <= 1'b0;
        end else begin
            reply_done <= 1'b0;
            if (reply_start) begin
                spi_oe <= 1'b1;
                nbl_left <= status_only ? '0 : LEFT_W'(`SPI_ID_NBL);
            end else if (spi_oe) begin
                if (nbl_left == '0) begin
                    spi_oe <= 1'b0;
                    reply_done <= 1'b1;
                end else begin
                    nbl_left <= nbl_left - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sck) begin
        if (reply_start) begin
            if (status_only) begin
                rep_sr <= {reply_status, `SPI_ID_W'(0)};
            end else begin
                rep_sr <= {(reply_kind == spi_cmd_pkg::OP_CREATE_TRI) ? tri_id : vert_id,
                           reply_status};
            end
        end else if (spi_oe) begin
            rep_sr <= rep_sr << `SPI_NBL_W;   // next nibble to the top
        end
    end

    a_oe_max_three: assert property (@(posedge sck) disable iff (rst)
        spi_oe [*3] |=> !spi_oe);

endmodule

`default_nettype wire

// File: hdl/spi_cmd_consts.svh
`ifndef SPI_CMD_CONSTS_SVH
`define SPI_CMD_CONSTS_SVH

// one quad-SPI transfer
`define SPI_NBL_W 4

`define SPI_SETTLE_CYC 8   // ignored cycles after cs_n falls

// payload widths
`define SPI_VTX_W 108
`define SPI_TRI_W 24
`define SPI_CNT_W 8
`define SPI_ID_W 8

// geometry memory
`define SPI_VERT_ADDR_W 13
`define SPI_TRI_ADDR_W 13
`define SPI_MAX_VERT 8192
`define SPI_MAX_TRI 8192

// nibbles per field
`define SPI_VTX_NBL (`SPI_VTX_W / `SPI_NBL_W)
`define SPI_TRI_NBL (`SPI_TRI_W / `SPI_NBL_W)
`define SPI_CNT_NBL (`SPI_CNT_W / `SPI_NBL_W)
`define SPI_ID_NBL (`SPI_ID_W / `SPI_NBL_W)

`endif

// File: hdl/spi_cmd_pkg.sv
`default_nettype none
`include "spi_cmd_consts.svh"

package spi_cmd_pkg;

    typedef logic [`SPI_NBL_W-1:0] nibble_t;
    typedef logic [`SPI_VTX_W-1:0] vertex_t;
    typedef logic [`SPI_TRI_W-1:0] tri_t;     // three vertex indices
    typedef logic [`SPI_CNT_W-1:0] count_t;
    typedef logic [`SPI_ID_W-1:0] buf_id_t;
    typedef logic [`SPI_VERT_ADDR_W-1:0] vert_addr_t;
    typedef logic [`SPI_TRI_ADDR_W-1:0] tri_addr_t;

    typedef enum logic [`SPI_NBL_W-1:0] {
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2
    } opcode_e;

    // sent back as the last reply nibble
    typedef enum logic [`SPI_NBL_W-1:0] {
        ST_OK             = 4'd0,
        ST_INVALID_OPCODE = 4'd1,
        ST_OUT_OF_MEMORY  = 4'd2
    } status_e;

    typedef enum logic [3:0] {
        PS_OP,
        PS_CNT,
        PS_VERT,
        PS_TRI,
        PS_DONE,    // last item valid cycle
        PS_REPLY
    } parse_state_e;

endpackage

`default_nettype wire

// File: hdl/spi_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module spi_cmd_top (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cs_n,
    input  spi_cmd_pkg::nibble_t    spi_in,
    output spi_cmd_pkg::nibble_t    spi_out,
    output logic                    spi_oe,
    output logic                    vert_hdr_valid,
    output spi_cmd_pkg::buf_id_t    vert_id,
    output spi_cmd_pkg::vert_addr_t vert_base,
    output spi_cmd_pkg::count_t     vert_count,
    output logic                    vert_valid,
    output spi_cmd_pkg::vertex_t    vert_data,
    output logic                    tri_hdr_valid,
    output spi_cmd_pkg::buf_id_t    tri_id,
    output spi_cmd_pkg::tri_addr_t  tri_base,
    output spi_cmd_pkg::count_t     tri_count,
    output logic                    tri_valid,
    output spi_cmd_pkg::tri_t       tri_data
);
    logic vert_alloc_req;
    logic tri_alloc_req;
    spi_cmd_pkg::count_t count;
    spi_cmd_pkg::status_e vert_status;
    spi_cmd_pkg::status_e tri_status;
    logic reply_start;
    spi_cmd_pkg::opcode_e reply_kind;
    spi_cmd_pkg::status_e reply_status;
    logic reply_done;

    cmd_parser parser_i (
        .sck, .rst, .cs_n, .spi_in,
        .vert_status, .tri_status, .reply_done,
        .vert_alloc_req, .tri_alloc_req, .count,
        .vert_valid, .vert_data, .tri_valid, .tri_data,
        .reply_start, .reply_kind, .reply_status
    );

    buf_allocator #(.ADDR_W(`SPI_VERT_ADDR_W), .CAPACITY(`SPI_MAX_VERT)) vert_alloc_i (
        .sck, .rst,
        .alloc_req    (vert_alloc_req),
        .count        (count),
        .hdr_valid    (vert_hdr_valid),
        .id           (vert_id),
        .base         (vert_base),
        .alloc_status (vert_status),
        .hdr_count    (vert_count)
    );

    buf_allocator #(.ADDR_W(`SPI_TRI_ADDR_W), .CAPACITY(`SPI_MAX_TRI)) tri_alloc_i (
        .sck, .rst,
        .alloc_req    (tri_alloc_req),
        .count        (count),
        .hdr_valid    (tri_hdr_valid),
        .id           (tri_id),
        .base         (tri_base),
        .alloc_status (tri_status),
        .hdr_count    (tri_count)
    );

    reply_serializer serializer_i (
        .sck, .rst, .reply_start, .reply_kind,
        .vert_id, .tri_id, .reply_status,
        .spi_out, .spi_oe, .reply_done
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/spi_cmd_pkg.sv
hdl/cmd_parser.sv
hdl/buf_allocator.sv
hdl/reply_serializer.sv
hdl/spi_cmd_top.sv
tb/spi_cmd_checker.sv
tb/tb_spi_cmd.sv

// File: tb/spi_cmd_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module spi_cmd_checker (
    input logic                    sck,
    input logic                    rst,
    input spi_cmd_pkg::nibble_t    spi_out,
    input logic                    spi_oe,
    input logic                    vert_hdr_valid,
    input spi_cmd_pkg::buf_id_t    vert_id,
    input spi_cmd_pkg::vert_addr_t vert_base,
    input spi_cmd_pkg::count_t     vert_count,
    input logic                    vert_valid,
    input spi_cmd_pkg::vertex_t    vert_data,
    input logic                    tri_hdr_valid,
    input spi_cmd_pkg::buf_id_t    tri_id,
    input spi_cmd_pkg::tri_addr_t  tri_base,
    input spi_cmd_pkg::count_t     tri_count,
    input logic                    tri_valid,
    input spi_cmd_pkg::tri_t       tri_data
);
    localparam int VW = `SPI_VTX_W;

    int hdr_errs = 0;
    int item_errs = 0;
    int reply_errs = 0;
    int proto_errs = 0;
    string test_name = "";
    logic [VW-1:0] item_q[$];
    spi_cmd_pkg::nibble_t reply_q[$];
    spi_cmd_pkg::buf_id_t vert_next_id = '0;
    spi_cmd_pkg::buf_id_t tri_next_id = '0;
    int vert_next_base = 0;
    int tri_next_base = 0;
    logic want_vert = 1'b0;   // command in flight creates a vertex buffer
    logic want_tri = 1'b0;
    logic hdr_seen = 1'b0;
    spi_cmd_pkg::buf_id_t exp_id;
    int exp_base;
    int exp_count;
    int items_exp = 0;
    int items_seen = 0;

    function automatic int differs(input string what, input logic [VW-1:0] exp,
                                   input logic [VW-1:0] act);
        if (exp !== act) begin
            $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
            return 1;
        end
        return 0;
    endfunction

    task automatic close_cmd();
        if ((want_vert || want_tri) && !hdr_seen) begin
            $display("ERROR %s: no buffer header was seen", test_name);
            proto_errs++;
        end
        if (items_seen != items_exp) begin
            $display("ERROR %s: %0d item valids seen where %0d were due",
                     test_name, items_seen, items_exp);
            proto_errs++;
        end
        if (reply_q.size() != 0) begin
            $display("ERROR %s: reply ended %0d nibbles short", test_name, reply_q.size());
            proto_errs++;
        end
    endtask

    task automatic start_cmd(input string name, input spi_cmd_pkg::nibble_t op,
                             input spi_cmd_pkg::count_t cnt,
                             input spi_cmd_pkg::buf_id_t rep_id,
                             input spi_cmd_pkg::nibble_t rep_st);
        int cap;
        spi_cmd_pkg::status_e st;
        close_cmd();
        test_name = name;
        want_vert = (op == spi_cmd_pkg::OP_CREATE_VERT);
        want_tri = (op == spi_cmd_pkg::OP_CREATE_TRI);
        hdr_seen = 1'b0;
        items_seen = 0;
        items_exp = 0;
        item_q.delete();
        st = spi_cmd_pkg::ST_INVALID_OPCODE;
        if (want_vert || want_tri) begin
            exp_id = want_vert ? vert_next_id : tri_next_id;
            exp_base = want_vert ? vert_next_base : tri_next_base;
            exp_count = int'(cnt);
            cap = want_vert ? `SPI_MAX_VERT : `SPI_MAX_TRI;
            st = spi_cmd_pkg::ST_OUT_OF_MEMORY;   // nothing advances
            if (exp_base + exp_count <= cap) begin
                st = spi_cmd_pkg::ST_OK;
                items_exp = exp_count;
                if (want_vert) begin
                    vert_next_id++;
                    vert_next_base += exp_count;
                end else begin
                    tri_next_id++;
                    tri_next_base += exp_count;
                end
            end
            reply_q.push_back(rep_id[7:4]);
            reply_q.push_back(rep_id[3:0]);
        end
        reply_q.push_back(rep_st);
        if (rep_st !== st || ((want_vert || want_tri) && rep_id !== exp_id)) begin
            $display("ERROR %s: vectors file reply disagrees with the allocation model", name);
            proto_errs++;
        end
    endtask

    task automatic add_item(input logic [VW-1:0] data);
        item_q.push_back(data);
    endtask

    task automatic check_header(input logic expected, input string kind,
                                input spi_cmd_pkg::buf_id_t id, input int base,
                                input int addr_w, input spi_cmd_pkg::count_t cnt);
        if (!expected || hdr_seen) begin
            $display("ERROR %s: %s header that the command does not call for", test_name, kind);
            proto_errs++;
        end else begin
            hdr_seen = 1'b1;
            hdr_errs += differs({kind, " id"}, VW'(exp_id), VW'(id));
            // base port only holds the low address bits
            hdr_errs += differs({kind, " base"}, VW'(exp_base % (1 << addr_w)), VW'(base));
            hdr_errs += differs({kind, " count"}, VW'(exp_count), VW'(cnt));
        end
    endtask

    task automatic check_item(input logic expected, input string kind,
                              input logic [VW-1:0] data);
        if (!expected || items_seen >= items_exp || item_q.size() == 0) begin
            $display("ERROR %s: %s item valid with no item due", test_name, kind);
            proto_errs++;
        end else begin
            items_seen++;
            item_errs += differs({kind, " item"}, item_q.pop_front(), data);
        end
    endtask

    always @(posedge sck) begin
        if (!rst) begin
            if (vert_hdr_valid) begin
                check_header(want_vert, "vertex", vert_id, int'(vert_base),
                             `SPI_VERT_ADDR_W, vert_count);
            end
            if (tri_hdr_valid) begin
                check_header(want_tri, "triangle", tri_id, int'(tri_base),
                             `SPI_TRI_ADDR_W, tri_count);
            end
            if (vert_valid) check_item(want_vert, "vertex", vert_data);
            if (tri_valid) check_item(want_tri, "triangle", VW'(tri_data));
            if (spi_oe) begin
                if (reply_q.size() == 0) begin
                    $display("ERROR %s: spi_oe high with no reply due", test_name);
                    proto_errs++;
                end else begin
                    reply_errs += differs("reply nibble", VW'(reply_q.pop_front()), VW'(spi_out));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/spi_cmd_vectors.txt
# columns: name opcode count repeats reply_id reply_status (hex, repeats in decimal)
# items are random; with repeats the reply id steps by one per command
vert_first 1 03 1 00 0
tri_first 2 05 1 00 0
vert_second 1 04 1 01 0
bad_op_7 7 00 1 00 1
vert_after_bad 1 02 1 02 0
vert_fill 1 ff 32 03 0
vert_oom 1 18 1 23 2
vert_last_fit 1 17 1 23 0
vert_full 1 01 1 24 2
tri_second 2 02 1 01 0
bad_op_0 0 00 1 00 1
bad_op_f f 00 1 00 1
tri_third 2 01 1 02 0

// File: tb/tb_spi_cmd.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_cmd_consts.svh"

module tb_spi_cmd;
    localparam int VW = `SPI_VTX_W;
    localparam int REPLY_WAIT = 64;   // cycles from last nibble to reply

    logic sck;
    logic rst;
    logic cs_n;
    spi_cmd_pkg::nibble_t spi_in;
    spi_cmd_pkg::nibble_t spi_out;
    logic spi_oe;
    logic vert_hdr_valid;
    spi_cmd_pkg::buf_id_t vert_id;
    spi_cmd_pkg::vert_addr_t vert_base;
    spi_cmd_pkg::count_t vert_count;
    logic vert_valid;
    spi_cmd_pkg::vertex_t vert_data;
    logic tri_hdr_valid;
    spi_cmd_pkg::buf_id_t tri_id;
    spi_cmd_pkg::tri_addr_t tri_base;
    spi_cmd_pkg::count_t tri_count;
    logic tri_valid;
    spi_cmd_pkg::tri_t tri_data;
    int timeouts;
    int file_errs;
    logic in_frame;   // cs_n still low after a status-only reply

    spi_cmd_top dut_i (.*);

    spi_cmd_checker chk_i (.*);

    initial begin
        sck = 1'b0;
        forever #2 sck = ~sck;
    end

    function automatic spi_cmd_pkg::nibble_t random_nibble();
        return spi_cmd_pkg::nibble_t'($urandom);
    endfunction

    task automatic send(input spi_cmd_pkg::nibble_t nib);
        @(posedge sck);
        spi_in <= nib;
    endtask

    // settle junk on a new frame then opcode, count, items and the reply
    task automatic run_command(input string name, input spi_cmd_pkg::nibble_t op,
                               input spi_cmd_pkg::count_t cnt,
                               input spi_cmd_pkg::buf_id_t rep_id,
                               input spi_cmd_pkg::nibble_t rep_st);
        logic [VW-1:0] item;
        int nbls;
        int reply_len;
        int k;
        int t;
        if (in_frame) begin
            spi_in <= op;   // cycle right after the previous reply
            @(negedge sck);
            chk_i.start_cmd(name, op, cnt, rep_id, rep_st);
        end else begin
            chk_i.start_cmd(name, op, cnt, rep_id, rep_st);
            @(posedge sck);
            cs_n <= 1'b0;
            spi_in <= random_nibble();
            repeat (`SPI_SETTLE_CYC - 1) send(random_nibble());
            send(op);
        end
        reply_len = 1;
        if (op == spi_cmd_pkg::OP_CREATE_VERT || op == spi_cmd_pkg::OP_CREATE_TRI) begin
            reply_len = 3;
            send(cnt[7:4]);
            send(cnt[3:0]);
            nbls = (op == spi_cmd_pkg::OP_CREATE_VERT) ? `SPI_VTX_NBL : `SPI_TRI_NBL;
            repeat (cnt) begin
                item = VW'({$urandom, $urandom, $urandom, $urandom});
                if (op == spi_cmd_pkg::OP_CREATE_TRI) begin
                    item = VW'(item[`SPI_TRI_W-1:0]);
                end
                chk_i.add_item(item);
                for (k = nbls - 1; k >= 0; k--) begin
                    send(item[4*k +: 4]);
                end
            end
        end
        t = 0;
        @(posedge sck);
        while (spi_oe !== 1'b1 && t < REPLY_WAIT) begin
            spi_in <= random_nibble();
            @(posedge sck);
            t++;
        end
        if (spi_oe !== 1'b1) begin
            $display("ERROR %s: no reply came within %0d cycles", name, REPLY_WAIT);
            timeouts++;
        end
        // next opcode follows a status-only reply in the same frame
        in_frame = (reply_len == 1) && (spi_oe === 1'b1);
        // junk on the remaining reply cycles
        repeat (reply_len - 1) begin
            spi_in <= random_nibble();
            @(posedge sck);
        end
        if (!in_frame) begin
            cs_n <= 1'b1;
            spi_in <= random_nibble();
            repeat (2) @(posedge sck);
        end
    endtask

    initial begin
        int fd;
        int n;
        int reps;
        string line;
        string name;
        spi_cmd_pkg::nibble_t op;
        spi_cmd_pkg::count_t cnt;
        spi_cmd_pkg::buf_id_t rep_id;
        spi_cmd_pkg::nibble_t rep_st;
        void'($urandom(32'h76d0_a9dd));
        timeouts = 0;
        file_errs = 0;
        in_frame = 1'b0;
        rst = 1'b1;
        cs_n = 1'b1;
        spi_in = '0;
        repeat (2) @(posedge sck);
        rst <= 1'b0;
        fd = $fopen("tb/spi_cmd_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR the vectors file tb/spi_cmd_vectors.txt could not be opened");
            file_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %d %h %h", name, op, cnt, reps, rep_id, rep_st);
                    if (n != 6) begin
                        $display("ERROR vectors line could not be parsed: %s", line);
                        file_errs++;
                    end else begin
                        repeat (reps) begin
                            run_command(name, op, cnt, rep_id, rep_st);
                            rep_id = rep_id + 1'b1;   // ids step per repeat
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (in_frame) begin
            cs_n <= 1'b1;
            repeat (2) @(posedge sck);
        end
        chk_i.close_cmd();
        $display("errors: header %0d, item %0d, reply %0d, protocol %0d, timeout %0d, file %0d",
                 chk_i.hdr_errs, chk_i.item_errs, chk_i.reply_errs, chk_i.proto_errs,
                 timeouts, file_errs);
        if (chk_i.hdr_errs + chk_i.item_errs + chk_i.reply_errs + chk_i.proto_errs
            + timeouts + file_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
